//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_loopback
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hc_pkg.sv
// shared sizes and word types, imported by the loopback RTL and its testbench
package hc_pkg;

  // ------------------------------------------------------------
  // data path
  // ------------------------------------------------------------
  localparam int WORD_W  = 64;
  localparam int ADDR_W  = 16;

  // transfer length, up to 1023 words
  localparam int COUNT_W = 10;

  // ------------------------------------------------------------
  // lanes
  // ------------------------------------------------------------
  localparam int NUM_LANES  = 4;
  localparam int LANE_W     = 2;

  // fifo entries per lane, also the read credits per lane
  localparam int LANE_DEPTH = 8;
  localparam int LANE_PTR_W = 3;

  // holds 0 .. LANE_DEPTH
  localparam int LANE_CNT_W = 4;

  // ------------------------------------------------------------
  // destination write credits
  // ------------------------------------------------------------
  localparam int WR_CREDITS = 4;

  // holds 0 .. WR_CREDITS
  localparam int WR_CNT_W   = 3;

  // ------------------------------------------------------------
  // types
  // ------------------------------------------------------------
  typedef logic [WORD_W-1:0]  t_word;
  typedef logic [ADDR_W-1:0]  t_addr;
  typedef logic [COUNT_W-1:0] t_count;
  typedef logic [LANE_W-1:0]  t_lane;

endpackage : hc_pkg

//--- list.f
hc_pkg.sv
read_sequencer.sv
loopback_lane.sv
write_drain.sv
loopback_top.sv
tb_mem_model.sv
tb_loopback.sv

//--- loopback_lane.sv
// one loopback lane, a small word fifo that returns a read credit for every pop
`timescale 1ns/1ps

module loopback_lane (
  input  logic          clk,
  input  logic          reset,
  input  logic          push,
  input  hc_pkg::t_word push_data,
  input  logic          pop,
  output logic          empty,
  output hc_pkg::t_word head_data,
  output logic          pop_credit
);

  import hc_pkg::*;

  t_word                 mem [LANE_DEPTH];
  logic [LANE_PTR_W-1:0] wr_ptr;
  logic [LANE_PTR_W-1:0] rd_ptr;
  logic [LANE_CNT_W-1:0] count;
  logic                  full;

  // ------------------------------------------------------------
  // status and head
  // ------------------------------------------------------------
  assign empty     = (count == '0);
  assign full      = (count == LANE_CNT_W'(LANE_DEPTH));

  // pushed word shows here the cycle after the push
  assign head_data = mem[rd_ptr];

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // ------------------------------------------------------------
  // pointers and occupancy
  // ------------------------------------------------------------
  // depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else begin
      count <= count + LANE_CNT_W'(push) - LANE_CNT_W'(pop);
    end
  end

  // ------------------------------------------------------------
  // credit back to the sequencer
  // ------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pop_credit <= 1'b0;
    end else begin
      pop_credit <= pop;
    end
  end

  // sequencer credits keep a full lane from being pushed
  assert property (@(posedge clk) disable iff (reset)
    push |-> !full);

  // drain only pops a lane showing a word
  assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty);

endmodule : loopback_lane

//--- loopback_top.sv
// loopback top, reads a source block through the lanes and writes it to the destination
`timescale 1ns/1ps

module loopback_top (
  input  logic           clk,
  input  logic           reset,
  input  logic           start,
  input  hc_pkg::t_addr  rd_base,
  input  hc_pkg::t_addr  wr_base,
  input  hc_pkg::t_count size,
  output logic           rd_req_valid,
  output hc_pkg::t_addr  rd_req_addr,
  input  logic           rd_rsp_valid,
  input  hc_pkg::t_word  rd_rsp_data,
  output logic           wr_valid,
  output hc_pkg::t_addr  wr_addr,
  output hc_pkg::t_word  wr_data,
  input  logic           wr_credit,
  output logic           finish
);

  import hc_pkg::*;

  logic [NUM_LANES-1:0]  rsp_push;
  t_word                 rsp_data;
  logic [NUM_LANES-1:0]  pop_credit;
  logic [NUM_LANES-1:0]  lane_pop;
  logic [NUM_LANES-1:0]  lane_empty;
  t_word [NUM_LANES-1:0] lane_data;
  logic                  xfer_start;
  t_count                xfer_size;

  // ------------------------------------------------------------
  // read side
  // ------------------------------------------------------------
  read_sequencer seq_i (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .rd_base      (rd_base),
    .size         (size),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_data  (rd_rsp_data),
    .pop_credit   (pop_credit),
    .rd_req_valid (rd_req_valid),
    .rd_req_addr  (rd_req_addr),
    .rsp_push     (rsp_push),
    .rsp_data     (rsp_data),
    .xfer_start   (xfer_start),
    .xfer_size    (xfer_size)
  );

  // ------------------------------------------------------------
  // lanes
  // ------------------------------------------------------------
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    loopback_lane lane_i (
      .clk        (clk),
      .reset      (reset),
      .push       (rsp_push[g]),
      .push_data  (rsp_data),
      .pop        (lane_pop[g]),
      .empty      (lane_empty[g]),
      .head_data  (lane_data[g]),
      .pop_credit (pop_credit[g])
    );
  end

  // ------------------------------------------------------------
  // write side
  // ------------------------------------------------------------
  write_drain drain_i (
    .clk        (clk),
    .reset      (reset),
    .xfer_start (xfer_start),
    .xfer_size  (xfer_size),
    .wr_base    (wr_base),
    .lane_empty (lane_empty),
    .lane_data  (lane_data),
    .wr_credit  (wr_credit),
    .lane_pop   (lane_pop),
    .wr_valid   (wr_valid),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .finish     (finish)
  );

endmodule : loopback_top

//--- read_sequencer.sv
// read side of the loopback that issues word reads under per-lane credits and steers responses
`timescale 1ns/1ps

module read_sequencer (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  hc_pkg::t_addr                rd_base,
  input  hc_pkg::t_count               size,
  input  logic                         rd_rsp_valid,
  input  hc_pkg::t_word                rd_rsp_data,
  input  logic [hc_pkg::NUM_LANES-1:0] pop_credit,
  output logic                         rd_req_valid,
  output hc_pkg::t_addr                rd_req_addr,
  output logic [hc_pkg::NUM_LANES-1:0] rsp_push,
  output hc_pkg::t_word                rsp_data,
  output logic                         xfer_start,
  output hc_pkg::t_count               xfer_size
);

  import hc_pkg::*;

  typedef enum logic {IDLE, READING} t_seq_state;

  t_seq_state            state;
  t_addr                 base_q;
  t_count                req_idx;
  t_lane                 req_lane;
  t_lane                 rsp_lane;
  logic                  all_full;
  logic                  seq_done;
  logic [LANE_CNT_W-1:0] credit [NUM_LANES];

  // ------------------------------------------------------------
  // start and read request
  // ------------------------------------------------------------
  always_comb begin
    all_full = 1'b1;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (credit[i] != LANE_CNT_W'(LANE_DEPTH)) begin
        all_full = 1'b0;
      end
    end
  end

  // every read issued and every word popped again
  assign seq_done     = (state == READING) && (req_idx == xfer_size) && all_full;
  assign xfer_start   = start && ((state == IDLE) || seq_done);
  assign req_lane     = req_idx[LANE_W-1:0];
  assign rd_req_valid = (state == READING) && (req_idx != xfer_size) &&
                        (credit[req_lane] != '0);
  assign rd_req_addr  = base_q + ADDR_W'(req_idx);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      req_idx   <= '0;
      xfer_size <= '0;
    end else if (xfer_start) begin
      state     <= READING;
      req_idx   <= '0;
      xfer_size <= size;
    end else begin
      if (seq_done) begin
        state <= IDLE;
      end
      if (rd_req_valid) begin
        req_idx <= req_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer_start) begin
      base_q <= rd_base;
    end
  end

  // spent on issue and returned on lane pop
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        credit[i] <= LANE_CNT_W'(LANE_DEPTH);
      end
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        credit[i] <= credit[i]
                   - LANE_CNT_W'(rd_req_valid && (req_lane == t_lane'(i)))
                   + LANE_CNT_W'(pop_credit[i]);
      end
    end
  end

  // ------------------------------------------------------------
  // read response through one register stage into the lanes
  // ------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rsp_push <= '0;
      rsp_lane <= '0;
    end else begin
      rsp_push <= rd_rsp_valid ? (NUM_LANES'(1) << rsp_lane) : '0;
      if (xfer_start) begin
        rsp_lane <= '0;
      end else if (rd_rsp_valid) begin
        rsp_lane <= rsp_lane + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    rsp_data <= rd_rsp_data;
  end

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_credit_chk
    // lane never hands back more than was spent
    assert property (@(posedge clk) disable iff (reset)
      credit[g] <= LANE_CNT_W'(LANE_DEPTH));
  end

endmodule : read_sequencer

//--- tb_loopback.sv
// testbench top for the loopback that runs the transfer tests while assertions check the DUT
`timescale 1ns/1ps

module tb_loopback;

  import hc_pkg::*;

  // words moved by all accepted transfers
  localparam int TOTAL_WORDS = 37 + 256 + 0 + 5 + 64 + 200 + 256 + 40;
  localparam int CYCLE_LIMIT = TOTAL_WORDS * 20 + 500;

  logic   clk;
  logic   reset;
  logic   start;
  t_addr  rd_base;
  t_addr  wr_base;
  t_count size;
  logic   rd_req_valid;
  t_addr  rd_req_addr;
  logic   rd_rsp_valid;
  t_word  rd_rsp_data;
  logic   wr_valid;
  t_addr  wr_addr;
  t_word  wr_data;
  logic   wr_credit;
  logic   finish;
  int     credit_max;

  // reference state following the accepted transfer
  logic   started;
  logic   xfer_open;
  t_addr  exp_rd_base;
  t_addr  exp_wr_base;
  t_count exp_size;
  t_count beat_idx;
  t_count rd_idx;
  t_addr  exp_req_addr;
  t_addr  exp_beat_addr;
  t_word  exp_beat_data;
  int     since_accept;
  int     reads_total;
  int     beats_total;
  int     credits_total;
  int     stalls;
  int     stall_mark;
  int     cycles;
  int     errors;
  int     mark;
  int     tests_run;
  int     tests_failed;

  always #2 clk = ~clk;

  loopback_top dut_i (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .rd_base      (rd_base),
    .wr_base      (wr_base),
    .size         (size),
    .rd_req_valid (rd_req_valid),
    .rd_req_addr  (rd_req_addr),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_data  (rd_rsp_data),
    .wr_valid     (wr_valid),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .wr_credit    (wr_credit),
    .finish       (finish)
  );

  tb_mem_model mem_i (
    .clk          (clk),
    .reset        (reset),
    .credit_max   (credit_max),
    .rd_req_valid (rd_req_valid),
    .rd_req_addr  (rd_req_addr),
    .wr_valid     (wr_valid),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_data  (rd_rsp_data),
    .wr_credit    (wr_credit)
  );

  // source word for an address as the memory holds it
  function automatic t_word expected_word(input t_addr a);
    return {a ^ 16'ha5c3, 16'(a * 16'd7), ~a, 16'(a + 16'h3c1f)};
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] got_val);
    $display("ERR %0t %s expected %h got %h", $time, name, exp_val, got_val);
    errors = errors + 1;
  endtask

  task automatic report_failure(input string what);
    $display("%0t: %s", $time, what);
    errors = errors + 1;
  endtask

  // ------------------------------------------------------------
  // reference tracking
  // ------------------------------------------------------------
  assign exp_req_addr  = exp_rd_base + t_addr'(rd_idx);
  assign exp_beat_addr = exp_wr_base + t_addr'(beat_idx);
  assign exp_beat_data = expected_word(exp_rd_base + t_addr'(beat_idx));

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      started       <= 1'b0;
      xfer_open     <= 1'b0;
      exp_rd_base   <= '0;
      exp_wr_base   <= '0;
      exp_size      <= '0;
      beat_idx      <= '0;
      rd_idx        <= '0;
      since_accept  <= 0;
      reads_total   <= 0;
      beats_total   <= 0;
      credits_total <= 0;
      stalls        <= 0;
    end else begin
      if (start) begin
        started <= 1'b1;
      end
      // a start while a transfer is open is dropped by the DUT
      if (start && !xfer_open) begin
        xfer_open    <= 1'b1;
        exp_rd_base  <= rd_base;
        exp_wr_base  <= wr_base;
        exp_size     <= size;
        beat_idx     <= '0;
        rd_idx       <= '0;
        since_accept <= 0;
      end else begin
        if (finish) begin
          xfer_open <= 1'b0;
        end
        if (wr_valid) begin
          beat_idx <= beat_idx + t_count'(1);
        end
        if (rd_req_valid) begin
          rd_idx <= rd_idx + t_count'(1);
        end
        since_accept <= since_accept + 1;
      end
      reads_total   <= reads_total + int'(rd_req_valid);
      beats_total   <= beats_total + int'(wr_valid);
      credits_total <= credits_total + int'(wr_credit);
      if (xfer_open && !rd_req_valid && rd_idx != exp_size) begin
        stalls <= stalls + 1;
      end
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  assert property (@(posedge clk) disable iff (reset) !started |-> !rd_req_valid)
    else report_mismatch("rd_req_valid", 0, $sampled(rd_req_valid));
  assert property (@(posedge clk) disable iff (reset) !started |-> !wr_valid)
    else report_mismatch("wr_valid", 0, $sampled(wr_valid));
  assert property (@(posedge clk) disable iff (reset) !started |-> !finish)
    else report_mismatch("finish", 0, $sampled(finish));

  assert property (@(posedge clk) disable iff (reset)
    rd_req_valid |-> rd_req_addr == exp_req_addr)
    else report_mismatch("rd_req_addr", $sampled(exp_req_addr), $sampled(rd_req_addr));
  assert property (@(posedge clk) disable iff (reset) rd_req_valid |-> rd_idx < exp_size)
    else report_failure("read request issued beyond the transfer size");

  assert property (@(posedge clk) disable iff (reset) wr_valid |-> wr_addr == exp_beat_addr)
    else report_mismatch("wr_addr", $sampled(exp_beat_addr), $sampled(wr_addr));
  assert property (@(posedge clk) disable iff (reset) wr_valid |-> wr_data == exp_beat_data)
    else report_mismatch("wr_data", $sampled(exp_beat_data), $sampled(wr_data));
  assert property (@(posedge clk) disable iff (reset) wr_valid |-> beat_idx < exp_size)
    else report_failure("write beat sent beyond the transfer size");

  // finish comes one cycle after the last beat and holds until a new start
  assert property (@(posedge clk) disable iff (reset) finish |-> beat_idx == exp_size)
    else report_mismatch("beat count at finish", $sampled(exp_size), $sampled(beat_idx));
  assert property (@(posedge clk) disable iff (reset)
    wr_valid && (beat_idx + 1 == exp_size) |=> finish)
    else report_mismatch("finish", 1, $sampled(finish));
  assert property (@(posedge clk) disable iff (reset) finish && !start |=> finish)
    else report_failure("finish dropped without a new start");
  assert property (@(posedge clk) disable iff (reset)
    $rose(finish) && exp_size == 0 |-> since_accept == 1)
    else report_mismatch("cycles to finish for size 0", 1, $sampled(since_accept));
  assert property (@(posedge clk) disable iff (reset)
    xfer_open && exp_size == 0 |-> !rd_req_valid && !wr_valid)
    else report_failure("read or write seen during a zero-size transfer");

  assert property (@(posedge clk) disable iff (reset)
    beats_total - credits_total <= WR_CREDITS)
    else report_mismatch("write credits in use", WR_CREDITS,
                         $sampled(beats_total - credits_total));
  assert property (@(posedge clk) disable iff (reset)
    reads_total - beats_total <= NUM_LANES * LANE_DEPTH + 1)
    else report_mismatch("reads ahead of writes", NUM_LANES * LANE_DEPTH + 1,
                         $sampled(reads_total - beats_total));

  // ------------------------------------------------------------
  // run limit
  // ------------------------------------------------------------
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("timeout: transfers still not finished after %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  task automatic launch(input t_addr rd, input t_addr wr, input t_count n, input int cmax);
    @(posedge clk);
    start      <= 1'b1;
    rd_base    <= rd;
    wr_base    <= wr;
    size       <= n;
    credit_max <= cmax;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_finish();
    @(negedge clk);
    while (!finish) begin
      @(negedge clk);
    end
  endtask

  task automatic run_xfer(input t_addr rd, input t_addr wr, input t_count n, input int cmax);
    launch(rd, wr, n, cmax);
    wait_finish();
  endtask

  task automatic close_test(input int num, input string name);
    tests_run = tests_run + 1;
    if (errors == mark) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %0d %s: %0d errors", num, name, errors - mark);
    end
    mark = errors;
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    rd_base      = '0;
    wr_base      = '0;
    size         = '0;
    credit_max   = 5;
    cycles       = 0;
    errors       = 0;
    mark         = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    repeat (10) @(posedge clk);
    close_test(1, "reset");

    run_xfer(16'h0100, 16'h4000, 37, 5);
    run_xfer(16'hfff0, 16'h8000, 256, 5);
    close_test(2, "data and order");

    run_xfer(16'h2000, 16'h9000, 0, 5);
    run_xfer(16'h2100, 16'h9100, 5, 5);
    close_test(3, "completion");

    run_xfer(16'h3000, 16'ha000, 64, 20);
    close_test(4, "destination credits");

    // slow credits back up the lanes until reads stall
    stall_mark = stalls;
    run_xfer(16'h4000, 16'hb000, 200, 16);
    assert (stalls != stall_mark)
      else report_failure("read issue never stalled under back-pressure");
    close_test(5, "lane credits");

    launch(16'h5000, 16'hc000, 256, 5);
    while (beat_idx < 20) begin
      @(negedge clk);
    end
    launch(16'h7000, 16'he000, 100, 5);
    wait_finish();
    run_xfer(16'h6000, 16'hd000, 40, 5);
    close_test(6, "start while busy");

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule : tb_loopback

//--- tb_mem_model.sv
// testbench memory model, answers reads in order after a random latency and returns write credits late
`timescale 1ns/1ps

module tb_mem_model (
  input  logic          clk,
  input  logic          reset,
  input  int            credit_max,
  input  logic          rd_req_valid,
  input  hc_pkg::t_addr rd_req_addr,
  input  logic          wr_valid,
  output logic          rd_rsp_valid,
  output hc_pkg::t_word rd_rsp_data,
  output logic          wr_credit
);

  import hc_pkg::*;

  localparam logic [31:0] SEED    = 32'h81c0_6ddf;
  localparam int          LAT_MAX = 6;

  logic [31:0] rng;
  longint      now;
  longint      last_rsp;
  longint      last_credit;
  longint      rsp_due [$];
  t_addr       rsp_addr [$];
  longint      credit_due [$];

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // source buffer contents, a fixed mix of the address
  function automatic t_word source_word(input t_addr a);
    return {a ^ 16'ha5c3, 16'(a * 16'd7), ~a, 16'(a + 16'h3c1f)};
  endfunction

  // ------------------------------------------------------------
  // request capture and in-order replies
  // ------------------------------------------------------------
  always @(posedge clk or posedge reset) begin
    longint due;
    if (reset) begin
      rng          = SEED;
      now          = 0;
      last_rsp     = -1;
      last_credit  = -1;
      rsp_due.delete();
      rsp_addr.delete();
      credit_due.delete();
      rd_rsp_valid <= 1'b0;
      rd_rsp_data  <= '0;
      wr_credit    <= 1'b0;
    end else begin
      // due times strictly rise, one reply per cycle and in order
      if (rd_req_valid) begin
        rng = lcg_next(rng);
        due = now + longint'(rng[31:16]) % LAT_MAX;
        if (due <= last_rsp) begin
          due = last_rsp + 1;
        end
        last_rsp = due;
        rsp_due.push_back(due);
        rsp_addr.push_back(rd_req_addr);
      end
      if (wr_valid) begin
        rng = lcg_next(rng);
        due = now + longint'(rng[31:16]) % longint'(credit_max);
        if (due <= last_credit) begin
          due = last_credit + 1;
        end
        last_credit = due;
        credit_due.push_back(due);
      end

      rd_rsp_valid <= 1'b0;
      if (rsp_due.size() != 0 && rsp_due[0] <= now) begin
        rd_rsp_valid <= 1'b1;
        rd_rsp_data  <= source_word(rsp_addr[0]);
        void'(rsp_due.pop_front());
        void'(rsp_addr.pop_front());
      end

      wr_credit <= 1'b0;
      if (credit_due.size() != 0 && credit_due[0] <= now) begin
        wr_credit <= 1'b1;
        void'(credit_due.pop_front());
      end
      now = now + 1;
    end
  end

endmodule : tb_mem_model

//--- write_drain.sv
// write side of the loopback that drains lanes in round-robin order into credited write beats
`timescale 1ns/1ps

module write_drain (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    xfer_start,
  input  hc_pkg::t_count                          xfer_size,
  input  hc_pkg::t_addr                           wr_base,
  input  logic [hc_pkg::NUM_LANES-1:0]            lane_empty,
  input  hc_pkg::t_word [hc_pkg::NUM_LANES-1:0]   lane_data,
  input  logic                                    wr_credit,
  output logic [hc_pkg::NUM_LANES-1:0]            lane_pop,
  output logic                                    wr_valid,
  output hc_pkg::t_addr                           wr_addr,
  output hc_pkg::t_word                           wr_data,
  output logic                                    finish
);

  import hc_pkg::*;

  logic                busy;
  t_count              beat_count;
  t_lane               lane_ptr;
  t_addr               base_q;
  logic [WR_CNT_W-1:0] credit;
  logic                pop_ok;

  // ------------------------------------------------------------
  // pop decision
  // ------------------------------------------------------------
  // only the pointed lane pops so stream order holds
  assign pop_ok   = busy && (beat_count != xfer_size) && !lane_empty[lane_ptr] &&
                    (credit != '0);
  assign lane_pop = pop_ok ? (NUM_LANES'(1) << lane_ptr) : '0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy       <= 1'b0;
      beat_count <= '0;
      lane_ptr   <= '0;
      finish     <= 1'b0;
      wr_valid   <= 1'b0;
    end else begin
      wr_valid <= pop_ok;
      if (xfer_start) begin
        busy       <= 1'b1;
        beat_count <= '0;
        lane_ptr   <= '0;
        finish     <= 1'b0;
      end else begin
        if (pop_ok) begin
          beat_count <= beat_count + 1'b1;
          lane_ptr   <= lane_ptr + 1'b1;
        end
        if (busy && (beat_count == xfer_size)) begin
          busy   <= 1'b0;
          finish <= 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // destination credits
  // ------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      credit <= WR_CNT_W'(WR_CREDITS);
    end else begin
      credit <= credit - WR_CNT_W'(pop_ok) + WR_CNT_W'(wr_credit);
    end
  end

  // ------------------------------------------------------------
  // write beat
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (xfer_start) begin
      base_q <= wr_base;
    end
    if (pop_ok) begin
      wr_addr <= base_q + ADDR_W'(beat_count);
      wr_data <= lane_data[lane_ptr];
    end
  end

  // destination returns no more than it was given
  assert property (@(posedge clk) disable iff (reset)
    credit <= WR_CNT_W'(WR_CREDITS));

endmodule : write_drain
